/* dmm_fpga.f */
common/dmm_pkg.sv
hdl/spi_regs/spi_register_set.sv
hdl/spi_route.sv
hdl/precharge_sequencer.sv
hdl/activity_latch.sv
hdl/output_mode_mux.sv
hdl/dmm_fpga_top.sv
verif/tb_dmm_fpga_top.sv

/* Makefile */
# Verilator simulation of the dmm_fpga testbench

VERILATOR ?= verilator
TOP       ?= tb_dmm_fpga_top
FILELIST  ?= dmm_fpga.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_dmm_fpga_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dmm_fpga_top;

  localparam int CLK_NS        = 40;
  localparam int HALF_SCK_CLKS = 4;                        // sck = clk/8
  localparam int FRAME_CLKS    = 40 * 2 * HALF_SCK_CLKS + 16;  // bits plus select gaps
  localparam int MAX_FRAMES    = 120;
  localparam int EXTRA_CLKS    = 5000;                     // idle waits and precharge runs
  localparam logic [31:0] PIN_MASK = 32'h01FF_F00F;        // monitor spare has no pin

  logic       clk_i;
  logic       arst_n_i;
  logic       sck_i;
  logic       sdi_i;
  logic       ss_n_i;
  logic       spi_cs2_n_i;
  logic       u1004_4094_data_i;
  logic [3:0] hw_flags_i;
  logic       sdo_o;
  logic       glb_spi_mosi_o;
  logic       glb_spi_clk_o;
  logic       glb_4094_oe_o;
  logic       glb_4094_strobe_o;
  logic       spi_dac_ss_o;
  logic [3:0] leds_o;
  logic [7:0] monitor_o;
  logic       spi_interrupt_ctl_o;
  logic       meas_complete_o;
  logic       sig_pc1_sw_o;
  logic       sig_pc2_sw_o;
  logic [3:0] azmux_o;
  logic       cmpr_latch_o;
  logic [3:0] refmux_o;

  logic [31:0] lcg_state = 32'd53;
  logic [31:0] model [0:15];    // written register values
  logic [3:0]  flags_now;
  logic        led_mid;         // leds_o[0] halfway through the last frame
  int          checks;
  int          errors;
  int          test_errors;
  int          tests;

  dmm_fpga_top dmm_fpga_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  // lcg draw from the upper half where the better bits are
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic logic [31:0] rand_word();
    logic [15:0] hi;
    logic [15:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = rand_word();
    return int'(r[30:0]) % n;
  endfunction

  // readback model with status built from flags and holes at 0
  function automatic logic [31:0] expected_read(input int addr);
    if (addr == 0) return {20'b0, flags_now, 8'hAA};
    if (addr >= 1 && addr <= 6) return model[addr];
    return 32'h0;
  endfunction

  // pins gathered back into control vector order
  function automatic logic [31:0] pin_vector();
    return {7'b0, refmux_o, cmpr_latch_o, azmux_o, sig_pc2_sw_o, sig_pc1_sw_o,
            meas_complete_o, spi_interrupt_ctl_o, 8'b0, leds_o};
  endfunction

  task automatic wait_clks(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;                       // drive slot after the edge
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic expect_cond(input string name, input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s: %s", name, what);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (test_errors == 0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // spi master in mode 0 with msb first

  task automatic spi_frame(input logic wr, input logic [6:0] addr,
                           input logic [31:0] data_in, output logic [31:0] data_out);
    logic [39:0] frame;
    frame    = {wr, addr, data_in};
    data_out = '0;
    ss_n_i   = 1'b0;
    for (int i = 39; i >= 0; i--) begin
      sdi_i = frame[i];
      wait_clks(HALF_SCK_CLKS);
      if (i < 32) data_out = {data_out[30:0], sdo_o};   // sampled on the rise
      sck_i = 1'b1;
      if (i == 20) led_mid = leds_o[0];
      wait_clks(HALF_SCK_CLKS);
      sck_i = 1'b0;
    end
    wait_clks(HALF_SCK_CLKS);
    ss_n_i = 1'b1;
    sdi_i  = 1'b0;
    wait_clks(HALF_SCK_CLKS);   // gap so the slave sees the frame end
  endtask

  task automatic reg_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    spi_frame(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input logic [6:0] addr, output logic [31:0] data);
    spi_frame(1'b0, addr, 32'h0, data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // precharge and routing helpers

  task automatic measure_pc_runs(input int p, input int a);
    logic prev;
    logic prev_led;
    logic run_led;
    logic found;
    int   wait_n;
    int   hi;
    int   lo;
    int   pulses;
    prev     = sig_pc1_sw_o;
    prev_led = leds_o[0];
    wait_n   = 0;
    hi       = 0;
    lo       = 0;
    pulses   = 0;
    while (!(sig_pc1_sw_o && !prev) && wait_n < 200) begin   // next sample start
      prev     = sig_pc1_sw_o;
      prev_led = leds_o[0];
      wait_clks(1);
      wait_n++;
    end
    found = sig_pc1_sw_o && !prev;
    expect_cond("precharge start", found, "sig_pc1_sw_o never rose after mode entry");
    if (found) begin
      run_led = leds_o[0];
      // led flips with each phase change
      check_value("precharge led toggle", {31'b0, !prev_led}, {31'b0, run_led});
      while (sig_pc1_sw_o && hi < 100) begin
        hi++;
        if (meas_complete_o) pulses++;
        wait_clks(1);
      end
      check_value("precharge led toggle", {31'b0, !run_led}, {31'b0, leds_o[0]});
      while (!sig_pc1_sw_o && lo < 100) begin
        lo++;
        if (meas_complete_o) pulses++;
        wait_clks(1);
      end
      check_value("precharge high run", 32'(a), 32'(hi));
      check_value("precharge low run", 32'(p), 32'(lo));
      check_value("precharge meas pulses", 32'd1, 32'(pulses));
    end
  endtask

  // random sck, mosi and chain data with cs2 low
  task automatic drive_route_cycles(input string name, input logic [1:0] route);
    logic [31:0] r;
    logic        sel_4094;
    logic        sel_dac;
    sel_4094 = (route == 2'd1);
    sel_dac  = (route == 2'd2);
    for (int n = 0; n < 8; n++) begin
      r                 = rand_word();
      sck_i             = r[0];
      sdi_i             = r[1];
      u1004_4094_data_i = r[2];
      #1;
      check_value(name,
                  {27'b0, (sel_4094 || sel_dac) && r[0], (sel_4094 || sel_dac) && r[1],
                   sel_4094, !sel_dac, sel_4094 && r[2]},
                  {27'b0, glb_spi_clk_o, glb_spi_mosi_o, glb_4094_strobe_o,
                   spi_dac_ss_o, sdo_o});
      check_value({name, " monitor"},
                  {29'b0, !sel_dac, (sel_4094 || sel_dac) && r[1],
                   (sel_4094 || sel_dac) && r[0]},
                  {24'b0, monitor_o});
      wait_clks(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog sized from the frame count

  initial begin
    repeat (MAX_FRAMES * FRAME_CLKS + EXTRA_CLKS) @(posedge clk_i);
    $display("timeout: watchdog expired before the tests finished");
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests

  initial begin
    logic [31:0] rd;
    logic [31:0] r;
    logic [31:0] direct;
    logic [3:0]  prev_leds;
    int          addr;
    int          p;
    int          a;
    arst_n_i          = 1'b0;
    sck_i             = 1'b0;
    sdi_i             = 1'b0;
    ss_n_i            = 1'b1;
    spi_cs2_n_i       = 1'b1;
    u1004_4094_data_i = 1'b0;
    hw_flags_i        = 4'h0;
    flags_now         = 4'h0;
    led_mid           = 1'b0;
    checks            = 0;
    errors            = 0;
    test_errors       = 0;
    tests             = 0;
    for (int i = 0; i < 16; i++) model[i] = 32'h0;
    repeat (5) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    wait_clks(2);

    // reset state then status with random flags
    check_value("reset pins", 32'h0, pin_vector());
    check_value("reset oe", 32'h0, {31'b0, glb_4094_oe_o});
    check_value("reset dac ss", 32'h1, {31'b0, spi_dac_ss_o});
    r          = rand_word();
    flags_now  = r[3:0];
    hw_flags_i = flags_now;
    reg_read(dmm_pkg::ADDR_STATUS, rd);
    check_value("reset status", expected_read(0), rd);
    finish_test("reset_state");

    // each frame returns the value before its own write
    for (int n = 0; n < 40; n++) begin
      addr = rand_below(10);
      r    = rand_word();
      spi_frame(1'b1, 7'(addr), r, rd);
      check_value("register write frame", expected_read(addr), rd);
      if (addr >= 1 && addr <= 6) model[addr] = r;
      reg_read(7'(addr), rd);
      check_value("register read", expected_read(addr), rd);
    end
    reg_write(dmm_pkg::ADDR_STATUS, rand_word());
    reg_read(dmm_pkg::ADDR_STATUS, rd);
    check_value("status read only", expected_read(0), rd);
    reg_write(7'd9, rand_word());
    reg_read(7'd9, rd);
    check_value("unknown address", 32'h0, rd);
    check_value("oe follows 4094 reg", {31'b0, model[2][0]}, {31'b0, glb_4094_oe_o});
    finish_test("register_access");

    // direct mode with led 0 from the activity latch
    reg_write(dmm_pkg::ADDR_MODE, 32'd0);
    direct = rand_word();
    reg_write(dmm_pkg::ADDR_DIRECT, direct);
    check_value("direct led in traffic", 32'h1, {31'b0, led_mid});
    wait_clks(int'(dmm_pkg::LED_HOLD_CYCLES) + 4);
    check_value("direct pins", {direct[31:1], 1'b0} & PIN_MASK, pin_vector());
    for (int k = 0; k < 4; k++) begin
      reg_write(dmm_pkg::ADDR_MODE, (k == 0) ? 32'd1 : 32'(k + 4));   // 1, 5, 6, 7
      check_value("zero mode pins", 32'h0, pin_vector());
    end
    reg_write(dmm_pkg::ADDR_MODE, 32'd2);
    check_value("ones mode pins", PIN_MASK, pin_vector());
    finish_test("static_modes");

    // counter low bits on the leds
    reg_write(dmm_pkg::ADDR_MODE, 32'd3);
    prev_leds = leds_o;
    for (int n = 0; n < 20; n++) begin
      wait_clks(1);
      check_value("pattern step", 32'(4'(prev_leds + 4'd1)), 32'(leds_o));
      prev_leds = leds_o;
    end
    finish_test("pattern_mode");

    for (int t = 0; t < 4; t++) begin
      reg_write(dmm_pkg::ADDR_MODE, 32'd0);
      p = 1 + rand_below(20);
      a = 1 + rand_below(20);
      reg_write(dmm_pkg::ADDR_PRECHARGE, 32'(p));
      reg_write(dmm_pkg::ADDR_APERTURE, 32'(a));
      reg_write(dmm_pkg::ADDR_MODE, 32'd4);   // restarts in precharge
      measure_pc_runs(p, a);
    end
    reg_write(dmm_pkg::ADDR_MODE, 32'd0);
    finish_test("precharge_mode");

    // 4094 then dac then none then code 3 as none
    for (int k = 0; k < 4; k++) begin
      r = (k == 0) ? 32'd1 : (k == 1) ? 32'd2 : (k == 2) ? 32'd0 : 32'd3;
      reg_write(dmm_pkg::ADDR_SPI_MUX, r);
      spi_cs2_n_i = 1'b0;
      drive_route_cycles("routing", r[1:0]);
      spi_cs2_n_i       = 1'b1;
      sck_i             = 1'b0;
      sdi_i             = 1'b0;
      u1004_4094_data_i = 1'b0;
      wait_clks(2);
      check_value("routing cs2 idle", 32'h1, {31'b0, spi_dac_ss_o});
    end
    finish_test("routing");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/dmm_fpga_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dmm_fpga_top (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       sck_i,            // at most clk/8
  input  logic       sdi_i,
  input  logic       ss_n_i,           // register set select
  input  logic       spi_cs2_n_i,      // routed peripheral select
  input  logic       u1004_4094_data_i,
  input  logic [3:0] hw_flags_i,
  output logic       sdo_o,
  output logic       glb_spi_mosi_o,
  output logic       glb_spi_clk_o,
  output logic       glb_4094_oe_o,
  output logic       glb_4094_strobe_o,
  output logic       spi_dac_ss_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic       spi_interrupt_ctl_o,
  output logic       meas_complete_o,
  output logic       sig_pc1_sw_o,
  output logic       sig_pc2_sw_o,
  output logic [3:0] azmux_o,
  output logic       cmpr_latch_o,
  output logic [3:0] refmux_o
);

  logic [3:0]         sync_meta;   // {ss_n, cs2_n, sck, sdi}
  logic [3:0]         sync_q;
  logic               sck_d;
  logic               sck_rise;
  logic               sck_fall;
  logic               reg_sdo;
  logic               act_led;
  logic               pc_sw;
  logic               pc_meas;
  logic               pc_led;
  logic [7:0]         pc_monitor;
  dmm_pkg::reg_word_t reg_spi_mux, reg_4094, reg_mode;
  dmm_pkg::reg_word_t reg_direct, reg_aperture, reg_precharge;
  dmm_pkg::ctrl_vec_t ctrl;

  ////////////////////////////////////////////////////////////////////////////
  // two flop sync, selects idle high

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_meta <= 4'b1100;
      sync_q    <= 4'b1100;
      sck_d     <= 1'b0;
    end else begin
      sync_meta <= {ss_n_i, spi_cs2_n_i, sck_i, sdi_i};
      sync_q    <= sync_meta;
      sck_d     <= sync_q[1];
    end
  end

  assign sck_rise = sync_q[1] && !sck_d;
  assign sck_fall = !sync_q[1] && sck_d;

  spi_register_set spi_register_set_inst (
    .clk_i, .arst_n_i,
    .ss_n_i(sync_q[3]), .sck_rise_i(sck_rise), .sck_fall_i(sck_fall),
    .sdi_i(sync_q[0]), .hw_flags_i, .sdo_o(reg_sdo),
    .reg_spi_mux_o(reg_spi_mux), .reg_4094_o(reg_4094), .reg_mode_o(reg_mode),
    .reg_direct_o(reg_direct), .reg_aperture_o(reg_aperture),
    .reg_precharge_o(reg_precharge)
  );

  spi_route spi_route_inst (
    .spi_cs2_n_i, .ss_n_i, .sck_i, .sdi_i,      // raw pins, no latency
    .reg_sdo_i(reg_sdo), .u1004_4094_data_i,
    .route_i(dmm_pkg::spi_mux_t'(reg_spi_mux[1:0])),
    .glb_spi_clk_o, .glb_spi_mosi_o, .glb_4094_strobe_o, .spi_dac_ss_o, .sdo_o
  );

  assign glb_4094_oe_o = reg_4094[0];
  assign monitor_o     = {5'b0, spi_dac_ss_o, glb_spi_mosi_o, glb_spi_clk_o};

  precharge_sequencer precharge_sequencer_inst (
    .clk_i, .arst_n_i,
    .enable_i(reg_mode[2:0] == dmm_pkg::MODE_PRECHARGE),
    .aperture_i(reg_aperture[23:0]), .precharge_i(reg_precharge[23:0]),
    .sw_pc_o(pc_sw), .meas_complete_o(pc_meas), .led_o(pc_led),
    .monitor_o(pc_monitor)
  );

  activity_latch activity_latch_inst (
    .clk_i, .arst_n_i,
    .trig_i(!sync_q[3] || !sync_q[2]),   // either select
    .led_o(act_led)
  );

  output_mode_mux output_mode_mux_inst (
    .clk_i, .arst_n_i,
    .mode_i(dmm_pkg::out_mode_e'(reg_mode[2:0])), .direct_i(reg_direct),
    .activity_led_i(act_led), .pc_sw_i(pc_sw), .pc_meas_i(pc_meas),
    .pc_led_i(pc_led), .pc_monitor_i(pc_monitor), .ctrl_o(ctrl)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pin split, monitor spare field not pinned

  assign leds_o              = ctrl[dmm_pkg::CTRL_LEDS_HI:dmm_pkg::CTRL_LEDS_LO];
  assign spi_interrupt_ctl_o = ctrl[dmm_pkg::CTRL_SPI_INTERRUPT];
  assign meas_complete_o     = ctrl[dmm_pkg::CTRL_MEAS_COMPLETE];
  assign sig_pc1_sw_o        = ctrl[dmm_pkg::CTRL_PC1];
  assign sig_pc2_sw_o        = ctrl[dmm_pkg::CTRL_PC2];
  assign azmux_o             = ctrl[dmm_pkg::CTRL_AZMUX_HI:dmm_pkg::CTRL_AZMUX_LO];
  assign cmpr_latch_o        = ctrl[dmm_pkg::CTRL_CMPR_LATCH];
  assign refmux_o            = ctrl[dmm_pkg::CTRL_REFMUX_HI:dmm_pkg::CTRL_REFMUX_LO];

endmodule

`default_nettype wire

/* hdl/output_mode_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module output_mode_mux (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  dmm_pkg::out_mode_e mode_i,
  input  dmm_pkg::reg_word_t direct_i,
  input  logic               activity_led_i,
  input  logic               pc_sw_i,         // precharge sequencer
  input  logic               pc_meas_i,
  input  logic               pc_led_i,
  input  logic [7:0]         pc_monitor_i,
  output dmm_pkg::ctrl_vec_t ctrl_o
);

  dmm_pkg::ctrl_vec_t pattern_q;   // free running, walks every pin
  dmm_pkg::ctrl_vec_t pc_vec;
  dmm_pkg::ctrl_vec_t ctrl_d;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) pattern_q <= '0;
    else           pattern_q <= pattern_q + 1'b1;
  end

  // precharge source, unused fields low
  always_comb begin
    pc_vec = '0;
    pc_vec[dmm_pkg::CTRL_LEDS_LO]                         = pc_led_i;
    pc_vec[dmm_pkg::CTRL_MON_HI:dmm_pkg::CTRL_MON_LO]     = pc_monitor_i;
    pc_vec[dmm_pkg::CTRL_MEAS_COMPLETE]                   = pc_meas_i;
    pc_vec[dmm_pkg::CTRL_PC1]                             = pc_sw_i;
  end

  always_comb begin
    case (mode_i)
      dmm_pkg::MODE_DIRECT:    ctrl_d = {direct_i[dmm_pkg::CTRL_BITS-1:1], activity_led_i};
      dmm_pkg::MODE_ZERO:      ctrl_d = '0;
      dmm_pkg::MODE_ONES:      ctrl_d = '1;
      dmm_pkg::MODE_PATTERN:   ctrl_d = pattern_q;
      dmm_pkg::MODE_PRECHARGE: ctrl_d = pc_vec;
      default:                 ctrl_d = '0;   // spare codes
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) ctrl_o <= '0;
    else           ctrl_o <= ctrl_d;     // glitch free pins
  end

  // spare mode codes drive everything low a clk later
  a_spare_mode_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mode_i > dmm_pkg::MODE_PRECHARGE |=> ctrl_o == '0);

endmodule

`default_nettype wire

/* hdl/activity_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module activity_latch (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic trig_i,     // any select low
  output logic led_o
);

  dmm_pkg::hold_cnt_t hold_q;   // clks left to hold

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_q <= '0;
    end else if (trig_i) begin
      hold_q <= dmm_pkg::LED_HOLD_CYCLES;   // retrigger
    end else if (hold_q != '0) begin
      hold_q <= hold_q - 1'b1;
    end
  end

  assign led_o = (hold_q != '0);

endmodule

`default_nettype wire

/* hdl/precharge_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module precharge_sequencer (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            enable_i,      // mode is precharge
  input  dmm_pkg::count_t aperture_i,    // sample length, clks
  input  dmm_pkg::count_t precharge_i,   // precharge length, clks
  output logic            sw_pc_o,
  output logic            meas_complete_o,
  output logic            led_o,
  output logic [7:0]      monitor_o
);

  typedef enum logic {PRECHARGE, SAMPLE} phase_e;

  phase_e          phase_q;
  dmm_pkg::count_t cnt_q;        // cycles left in phase, minus one
  logic            last_cycle;

  // terminal count for a phase, 0 runs as 1
  function automatic dmm_pkg::count_t phase_load(input dmm_pkg::count_t len);
    return (len == '0) ? '0 : len - 1'b1;
  endfunction

  assign last_cycle = enable_i && (cnt_q == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= PRECHARGE;
      cnt_q   <= '0;
      led_o   <= 1'b0;
    end else if (!enable_i) begin
      phase_q <= PRECHARGE;              // parked, restart on mode entry
      cnt_q   <= phase_load(precharge_i);
    end else if (last_cycle) begin
      led_o <= !led_o;                   // blink per phase
      if (phase_q == PRECHARGE) begin
        phase_q <= SAMPLE;
        cnt_q   <= phase_load(aperture_i);
      end else begin
        phase_q <= PRECHARGE;
        cnt_q   <= phase_load(precharge_i);
      end
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign sw_pc_o         = (phase_q == SAMPLE);   // switch closed to sample
  assign meas_complete_o = last_cycle && (phase_q == SAMPLE);
  assign monitor_o       = {phase_q == SAMPLE, cnt_q[23:17]};

  // sample starts only off a finished precharge
  a_sample_entry: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(sw_pc_o) |-> phase_q == SAMPLE && $past(phase_q == PRECHARGE && cnt_q == '0));

endmodule

`default_nettype wire

/* hdl/spi_route.sv */
`timescale 1ns/1ps
`default_nettype none

// cs2 peripheral routing, raw pins, no clock
module spi_route (
  input  logic              spi_cs2_n_i,
  input  logic              ss_n_i,
  input  logic              sck_i,
  input  logic              sdi_i,
  input  logic              reg_sdo_i,          // register set readback
  input  logic              u1004_4094_data_i,  // end of 4094 chain
  input  dmm_pkg::spi_mux_t route_i,
  output logic              glb_spi_clk_o,
  output logic              glb_spi_mosi_o,
  output logic              glb_4094_strobe_o,
  output logic              spi_dac_ss_o,
  output logic              sdo_o
);

  logic sel_4094;
  logic sel_dac;
  logic route_4094;
  logic route_dac;

  always_comb begin
    case (route_i)
      dmm_pkg::SPI_ROUTE_4094: {route_4094, route_dac} = 2'b10;
      dmm_pkg::SPI_ROUTE_DAC:  {route_4094, route_dac} = 2'b01;
      dmm_pkg::SPI_ROUTE_NONE: {route_4094, route_dac} = 2'b00;
      default:                 {route_4094, route_dac} = 2'b00;  // code 3
    endcase
  end

  assign sel_4094 = !spi_cs2_n_i && route_4094;
  assign sel_dac  = !spi_cs2_n_i && route_dac;

  // shared lines stay quiet unless a peripheral is selected
  assign glb_spi_clk_o     = (sel_4094 || sel_dac) && sck_i;
  assign glb_spi_mosi_o    = (sel_4094 || sel_dac) && sdi_i;
  assign glb_4094_strobe_o = sel_4094;          // strobe active high
  assign spi_dac_ss_o      = !sel_dac;          // dac select active low

  // own frame wins, then the chain readback
  assign sdo_o = !ss_n_i ? reg_sdo_i : (sel_4094 && u1004_4094_data_i);

endmodule

`default_nettype wire

/* hdl/spi_regs/spi_register_set.sv */
`timescale 1ns/1ps
`default_nettype none

// spi slave with all inputs already in the clk domain
module spi_register_set (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               ss_n_i,       // synchronized select
  input  logic               sck_rise_i,   // one clk strobe per edge
  input  logic               sck_fall_i,
  input  logic               sdi_i,
  input  logic [3:0]         hw_flags_i,
  output logic               sdo_o,
  output dmm_pkg::reg_word_t reg_spi_mux_o,
  output dmm_pkg::reg_word_t reg_4094_o,
  output dmm_pkg::reg_word_t reg_mode_o,
  output dmm_pkg::reg_word_t reg_direct_o,
  output dmm_pkg::reg_word_t reg_aperture_o,
  output dmm_pkg::reg_word_t reg_precharge_o
);

  dmm_pkg::bit_cnt_t              bit_cnt;     // rising edges this frame
  logic [dmm_pkg::FRAME_BITS-1:0] shift_in;
  dmm_pkg::reg_word_t             shift_out;   // msb drives sdo
  dmm_pkg::reg_word_t             rd_word;
  dmm_pkg::reg_word_t             status_word;
  logic                           commit_q;    // frame complete
  logic                           wr_flag;
  dmm_pkg::reg_addr_t             wr_addr;
  dmm_pkg::reg_word_t             wr_data;

  assign wr_flag = shift_in[39];
  assign wr_addr = shift_in[38:32];
  assign wr_data = shift_in[31:0];

  assign status_word = {20'b0, hw_flags_i, dmm_pkg::STATUS_MAGIC};

  ////////////////////////////////////////////////////////////////////////////
  // frame capture

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt  <= '0;
      commit_q <= 1'b0;
    end else begin
      commit_q <= 1'b0;
      if (ss_n_i) begin
        bit_cnt <= '0;                      // idle or short frame dropped
      end else if (sck_rise_i && bit_cnt != dmm_pkg::FRAME_BITS) begin
        bit_cnt  <= bit_cnt + 1'b1;
        commit_q <= (bit_cnt == dmm_pkg::FRAME_BITS - 1'b1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!ss_n_i && sck_rise_i && bit_cnt != dmm_pkg::FRAME_BITS) begin
      shift_in <= {shift_in[38:0], sdi_i};  // msb first
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback

  // address is the low 7 bits once the header is in
  always_comb begin
    case (dmm_pkg::reg_addr_t'(shift_in[6:0]))
      dmm_pkg::ADDR_STATUS:    rd_word = status_word;
      dmm_pkg::ADDR_SPI_MUX:   rd_word = reg_spi_mux_o;
      dmm_pkg::ADDR_4094:      rd_word = reg_4094_o;
      dmm_pkg::ADDR_MODE:      rd_word = reg_mode_o;
      dmm_pkg::ADDR_DIRECT:    rd_word = reg_direct_o;
      dmm_pkg::ADDR_APERTURE:  rd_word = reg_aperture_o;
      dmm_pkg::ADDR_PRECHARGE: rd_word = reg_precharge_o;
      default:                 rd_word = '0;   // unknown reads 0
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shift_out <= '0;
    end else if (ss_n_i) begin
      shift_out <= '0;
    end else if (sck_fall_i) begin
      if (bit_cnt == dmm_pkg::HEADER_BITS) begin
        shift_out <= rd_word;               // bit 31 out on first data fall
      end else if (bit_cnt > dmm_pkg::HEADER_BITS) begin
        shift_out <= {shift_out[30:0], 1'b0};
      end
    end
  end

  assign sdo_o = shift_out[31];

  ////////////////////////////////////////////////////////////////////////////
  // register bank

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_spi_mux_o   <= '0;
      reg_4094_o      <= '0;                // oe low at power up
      reg_mode_o      <= '0;                // direct mode
      reg_direct_o    <= '0;
      reg_aperture_o  <= '0;
      reg_precharge_o <= '0;
    end else if (commit_q && wr_flag) begin
      case (wr_addr)
        dmm_pkg::ADDR_SPI_MUX:   reg_spi_mux_o   <= wr_data;
        dmm_pkg::ADDR_4094:      reg_4094_o      <= wr_data;
        dmm_pkg::ADDR_MODE:      reg_mode_o      <= wr_data;
        dmm_pkg::ADDR_DIRECT:    reg_direct_o    <= wr_data;
        dmm_pkg::ADDR_APERTURE:  reg_aperture_o  <= wr_data;
        dmm_pkg::ADDR_PRECHARGE: reg_precharge_o <= wr_data;
        default: ;                          // status and holes ignored
      endcase
    end
  end

  // commit lands while the frame is still selected
  a_commit_in_frame: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    commit_q |-> !ss_n_i);

  a_bit_cnt_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bit_cnt <= dmm_pkg::FRAME_BITS);

endmodule

`default_nettype wire

/* common/dmm_pkg.sv */
`default_nettype none

package dmm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // spi register bus

  typedef logic [31:0] reg_word_t;   // one register
  typedef logic [6:0]  reg_addr_t;
  typedef logic [5:0]  bit_cnt_t;    // 0 .. FRAME_BITS

  localparam reg_addr_t ADDR_STATUS    = 7'd0;   // read only
  localparam reg_addr_t ADDR_SPI_MUX   = 7'd1;   // cs2 routing
  localparam reg_addr_t ADDR_4094      = 7'd2;   // bit 0 is oe
  localparam reg_addr_t ADDR_MODE      = 7'd3;
  localparam reg_addr_t ADDR_DIRECT    = 7'd4;
  localparam reg_addr_t ADDR_APERTURE  = 7'd5;   // sample phase, clks
  localparam reg_addr_t ADDR_PRECHARGE = 7'd6;   // precharge phase, clks

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;

  localparam bit_cnt_t FRAME_BITS  = 6'd40;  // wr flag, addr, data
  localparam bit_cnt_t HEADER_BITS = 6'd8;

  // cs2 routing, code 3 acts as none
  typedef logic [1:0] spi_mux_t;
  localparam spi_mux_t SPI_ROUTE_NONE = 2'd0;
  localparam spi_mux_t SPI_ROUTE_4094 = 2'd1;
  localparam spi_mux_t SPI_ROUTE_DAC  = 2'd2;

  typedef enum logic [2:0] {
    MODE_DIRECT    = 3'd0,
    MODE_ZERO      = 3'd1,
    MODE_ONES      = 3'd2,
    MODE_PATTERN   = 3'd3,
    MODE_PRECHARGE = 3'd4
  } out_mode_e;   // 5..7 give zero

  ////////////////////////////////////////////////////////////////////////////
  // control vector layout

  localparam int CTRL_BITS = 25;
  typedef logic [CTRL_BITS-1:0] ctrl_vec_t;

  localparam int CTRL_LEDS_LO       = 0;
  localparam int CTRL_LEDS_HI       = 3;
  localparam int CTRL_MON_LO        = 4;    // monitor spare
  localparam int CTRL_MON_HI        = 11;
  localparam int CTRL_SPI_INTERRUPT = 12;
  localparam int CTRL_MEAS_COMPLETE = 13;
  localparam int CTRL_PC1           = 14;
  localparam int CTRL_PC2           = 15;
  localparam int CTRL_AZMUX_LO      = 16;
  localparam int CTRL_AZMUX_HI      = 19;
  localparam int CTRL_CMPR_LATCH    = 20;
  localparam int CTRL_REFMUX_LO     = 21;
  localparam int CTRL_REFMUX_HI     = 24;

  ////////////////////////////////////////////////////////////////////////////
  // timing

  typedef logic [23:0] count_t;       // sequencer phase length
  typedef logic [4:0]  hold_cnt_t;
  localparam hold_cnt_t LED_HOLD_CYCLES = 5'd16;

endpackage

`default_nettype wire
